// ==== rtl/fp2_calc_pkg.sv ====
package fp2_calc_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 6;
    localparam int RAM_DEPTH = 1 << ADDR_W;   // 64 words
    localparam int OP_W      = 2;
    localparam int CMD_W     = OP_W + 3 * ADDR_W;

    // command word layout, ret in the low bits
    localparam int RET_LSB = 0;
    localparam int OPB_LSB = ADDR_W;
    localparam int OPA_LSB = 2 * ADDR_W;
    localparam int OP_LSB  = 3 * ADDR_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CMD_W-1:0]  cmd_t;

    typedef enum logic [OP_W-1:0] {
        ADD  = 2'd0,
        SUB  = 2'd1,
        DBL  = 2'd2,    // operand b unused
        CONJ = 2'd3     // operand b unused
    } alu_op_t;

    typedef enum logic [1:0] {
        IN_IDLE   = 2'd0,
        IN_LOAD   = 2'd1,
        IN_EXEC   = 2'd2,
        IN_RESULT = 2'd3
    } input_mode_t;

endpackage

// ==== rtl/ram_port_if.sv ====
`timescale 1ns/1ns

// read side of the operand RAM
interface ram_rd_if;
    import fp2_calc_pkg::*;

    addr_t addr1;
    addr_t addr2;
    word_t data1;
    word_t data2;

    modport seq (output addr1, output addr2);
    modport alu (input data1, input data2);
    modport ram (input addr1, input addr2, output data1, output data2);

endinterface

// write side, addresses from the sequencer and data from the ALU
interface ram_wr_if;
    import fp2_calc_pkg::*;

    logic  we1;
    logic  we2;
    addr_t addr1;
    addr_t addr2;
    word_t data1;
    word_t data2;

    modport seq (output we1, output we2, output addr1, output addr2);
    modport alu (output data1, output data2);
    modport ram (
        input we1,
        input we2,
        input addr1,
        input addr2,
        input data1,
        input data2
    );

endinterface

// ==== rtl/fp_add_sub.sv ====
`timescale 1ns/1ns

module fp_add_sub #(
    parameter int unsigned MODULUS = 65521
) (
    input  fp2_calc_pkg::word_t x,
    input  fp2_calc_pkg::word_t y,
    input  logic                sub,
    output fp2_calc_pkg::word_t z
);
    import fp2_calc_pkg::*;

    localparam logic [WORD_W:0] MOD_EXT = (WORD_W + 1)'(MODULUS);

    logic [WORD_W:0] sum;
    logic [WORD_W:0] diff;
    logic            borrow;
    logic            over;

    // one extra bit keeps the carry and the borrow
    assign sum    = {1'b0, x} + {1'b0, y};
    assign diff   = {1'b0, x} - {1'b0, y};
    assign borrow = diff[WORD_W];   // x below y
    assign over   = (sum >= MOD_EXT);

    always_comb begin
        if (sub) begin
            if (borrow) begin
                z = word_t'(diff + MOD_EXT);
            end else begin
                z = word_t'(diff);
            end
        end else begin
            if (over) begin
                z = word_t'(sum - MOD_EXT);
            end else begin
                z = word_t'(sum);
            end
        end
    end

endmodule

// ==== rtl/operand_ram.sv ====
`timescale 1ns/1ns

module operand_ram (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fp2_calc_pkg::input_mode_t input_mode,
    input  fp2_calc_pkg::addr_t       waddr1,
    input  fp2_calc_pkg::addr_t       waddr2,
    input  fp2_calc_pkg::word_t       wdata1,
    input  fp2_calc_pkg::word_t       wdata2,
    input  fp2_calc_pkg::addr_t       raddr1,
    input  fp2_calc_pkg::addr_t       raddr2,
    ram_rd_if.ram                     rd,
    ram_wr_if.ram                     wr,
    output fp2_calc_pkg::word_t       outdata1,
    output fp2_calc_pkg::word_t       outdata2
);
    import fp2_calc_pkg::*;

    word_t mem [RAM_DEPTH];

    logic  load;
    logic  exec;
    logic  result;
    logic  we1;
    logic  we2;
    addr_t wa1;
    addr_t wa2;
    word_t wd1;
    word_t wd2;
    addr_t ra1;
    addr_t ra2;
    word_t q1;
    word_t q2;

    assign load   = (input_mode == IN_LOAD);
    assign exec   = (input_mode == IN_EXEC);
    assign result = (input_mode == IN_RESULT);

    // external ports own the RAM while loading
    assign we1 = load || (exec && wr.we1);
    assign we2 = load || (exec && wr.we2);
    assign wa1 = load ? waddr1 : wr.addr1;
    assign wa2 = load ? waddr2 : wr.addr2;
    assign wd1 = load ? wdata1 : wr.data1;
    assign wd2 = load ? wdata2 : wr.data2;

    always_ff @(posedge clk) begin
        if (we1) begin
            mem[wa1] <= wd1;
        end
        if (we2) begin
            mem[wa2] <= wd2;   // port 2 wins on a shared address
        end
    end

    assign ra1 = result ? raddr1 : rd.addr1;
    assign ra2 = result ? raddr2 : rd.addr2;

    always_ff @(posedge clk) begin
        q1 <= mem[ra1];
        q2 <= mem[ra2];
    end

    assign rd.data1 = q1;
    assign rd.data2 = q2;

    assign outdata1 = result ? q1 : '0;
    assign outdata2 = result ? q2 : '0;

    // sequencer write strobes must never reach the RAM in another mode
    assert property (@(posedge clk) disable iff (!rst_n)
        (wr.we1 || wr.we2) |-> (input_mode == IN_EXEC));

endmodule

// ==== rtl/fp2_alu.sv ====
`timescale 1ns/1ns

module fp2_alu #(
    parameter int unsigned MODULUS = 65521
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  capture_a,
    input  logic                  capture_b,
    input  logic                  compute,
    input  fp2_calc_pkg::alu_op_t op,
    ram_rd_if.alu                 rd,
    ram_wr_if.alu                 wr
);
    import fp2_calc_pkg::*;

    word_t a0;
    word_t a1;
    word_t b0;
    word_t b1;
    word_t b0_op;
    word_t b1_op;
    word_t x0;
    word_t y0;
    word_t x1;
    word_t y1;
    logic  sub0;
    logic  sub1;
    word_t z0;
    word_t z1;
    word_t r0;
    word_t r1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a0 <= '0;
            a1 <= '0;
            b0 <= '0;
            b1 <= '0;
            r0 <= '0;
            r1 <= '0;
        end else begin
            if (capture_a) begin
                a0 <= rd.data1;
                a1 <= rd.data2;
            end
            if (capture_b) begin
                b0 <= rd.data1;
                b1 <= rd.data2;
            end
            if (compute) begin
                r0 <= z0;
                r1 <= z1;
            end
        end
    end

    // b is still on the read port in the compute cycle
    assign b0_op = capture_b ? rd.data1 : b0;
    assign b1_op = capture_b ? rd.data2 : b1;

    always_comb begin
        x0   = a0;
        y0   = b0_op;
        sub0 = 1'b0;
        x1   = a1;
        y1   = b1_op;
        sub1 = 1'b0;
        case (op)
            ADD, SUB: begin
                sub0 = (op == SUB);
                sub1 = (op == SUB);
            end
            DBL: begin
                y0 = a0;
                y1 = a1;
            end
            CONJ: begin
                y0   = '0;   // a0 + 0
                x1   = '0;   // 0 - a1
                y1   = a1;
                sub1 = 1'b1;
            end
            default: begin
                sub0 = 1'b0;
                sub1 = 1'b0;
            end
        endcase
    end

    fp_add_sub #(.MODULUS(MODULUS)) lane0 (.x(x0), .y(y0), .sub(sub0), .z(z0));
    fp_add_sub #(.MODULUS(MODULUS)) lane1 (.x(x1), .y(y1), .sub(sub1), .z(z1));

    assign wr.data1 = r0;
    assign wr.data2 = r1;

    // holds only while the RAM contents stay reduced
    assert property (@(posedge clk) disable iff (!rst_n)
        (r0 < MODULUS) && (r1 < MODULUS));

endmodule

// ==== rtl/calc_sequencer.sv ====
`timescale 1ns/1ns

module calc_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fp2_calc_pkg::input_mode_t input_mode,
    input  fp2_calc_pkg::cmd_t        top_cmd,
    ram_rd_if.seq                     rd,
    ram_wr_if.seq                     wr,
    output logic                      capture_a,
    output logic                      capture_b,
    output logic                      compute,
    output fp2_calc_pkg::alu_op_t     op,
    output logic                      finished_flag
);
    import fp2_calc_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        RD_A,
        RD_B,
        CALC,
        WR,
        DONE
    } calc_state_t;

    calc_state_t state;
    calc_state_t state_nxt;
    cmd_t        cmd_q;
    addr_t       opr_a;
    addr_t       opr_b;
    addr_t       ret;
    addr_t       rd_base;
    logic        exec;

    assign exec = (input_mode == IN_EXEC);

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            cmd_q <= top_cmd;   // frozen once the sequence starts
        end
    end

    assign op    = alu_op_t'(cmd_q[OP_LSB +: OP_W]);
    assign opr_a = cmd_q[OPA_LSB +: ADDR_W];
    assign opr_b = cmd_q[OPB_LSB +: ADDR_W];
    assign ret   = cmd_q[RET_LSB +: ADDR_W];

    always_comb begin
        state_nxt = state;
        if (!exec) begin
            state_nxt = IDLE;   // abort, nothing written
        end else begin
            case (state)
                IDLE:    state_nxt = RD_A;
                RD_A:    state_nxt = RD_B;
                RD_B:    state_nxt = CALC;
                CALC:    state_nxt = WR;
                WR:      state_nxt = DONE;
                DONE:    state_nxt = DONE;
                default: state_nxt = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign rd_base  = (state == RD_B) ? opr_b : opr_a;
    assign rd.addr1 = rd_base;
    assign rd.addr2 = rd_base + addr_t'(1);   // odd word of the pair

    assign capture_a = (state == RD_B);
    assign capture_b = (state == CALC);
    assign compute   = (state == CALC);

    assign wr.we1   = (state == WR) && exec;
    assign wr.we2   = (state == WR) && exec;
    assign wr.addr1 = ret;
    assign wr.addr2 = ret + addr_t'(1);

    assign finished_flag = (state == DONE);

    // both words are written together, right after the compute cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        (wr.we1 || wr.we2) |->
            (state == WR) && ($past(state) == CALC) && (wr.we1 == wr.we2));

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(finished_flag) |-> ($past(state) == WR));

endmodule

// ==== rtl/fp2_calc_core.sv ====
`timescale 1ns/1ns

module fp2_calc_core #(
    parameter int unsigned MODULUS = 65521
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fp2_calc_pkg::input_mode_t input_mode,
    input  fp2_calc_pkg::cmd_t        top_cmd,
    input  fp2_calc_pkg::addr_t       waddr1,
    input  fp2_calc_pkg::addr_t       waddr2,
    input  fp2_calc_pkg::word_t       wdata1,
    input  fp2_calc_pkg::word_t       wdata2,
    input  fp2_calc_pkg::addr_t       raddr1,
    input  fp2_calc_pkg::addr_t       raddr2,
    output fp2_calc_pkg::word_t       outdata1,
    output fp2_calc_pkg::word_t       outdata2,
    output logic                      finished_flag
);
    import fp2_calc_pkg::*;

    ram_rd_if rd_bus ();
    ram_wr_if wr_bus ();

    logic    capture_a;
    logic    capture_b;
    logic    compute;
    alu_op_t op;

    operand_ram u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .input_mode (input_mode),
        .waddr1     (waddr1),
        .waddr2     (waddr2),
        .wdata1     (wdata1),
        .wdata2     (wdata2),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rd         (rd_bus.ram),
        .wr         (wr_bus.ram),
        .outdata1   (outdata1),
        .outdata2   (outdata2)
    );

    fp2_alu #(.MODULUS(MODULUS)) u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture_a (capture_a),
        .capture_b (capture_b),
        .compute   (compute),
        .op        (op),
        .rd        (rd_bus.alu),
        .wr        (wr_bus.alu)
    );

    calc_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .input_mode    (input_mode),
        .top_cmd       (top_cmd),
        .rd            (rd_bus.seq),
        .wr            (wr_bus.seq),
        .capture_a     (capture_a),
        .capture_b     (capture_b),
        .compute       (compute),
        .op            (op),
        .finished_flag (finished_flag)
    );

endmodule

// ==== sim/tb_fp2_calc_core.sv ====
`timescale 1ns/1ns

module tb_fp2_calc_core;
    import fp2_calc_pkg::*;

    localparam int unsigned MODULUS = 65521;
    localparam int          TIMEOUT = 50;

    logic        clk;
    logic        rst_n;
    input_mode_t input_mode;
    cmd_t        top_cmd;
    addr_t       waddr1;
    addr_t       waddr2;
    word_t       wdata1;
    word_t       wdata2;
    addr_t       raddr1;
    addr_t       raddr2;
    word_t       outdata1;
    word_t       outdata2;
    logic        finished_flag;

    word_t  shadow [RAM_DEPTH];   // expected RAM contents
    integer seed;
    int     errors;
    int     err_at_start;
    int     tests_passed;
    int     tests_failed;

    fp2_calc_core #(.MODULUS(MODULUS)) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .input_mode    (input_mode),
        .top_cmd       (top_cmd),
        .waddr1        (waddr1),
        .waddr2        (waddr2),
        .wdata1        (wdata1),
        .wdata2        (wdata2),
        .raddr1        (raddr1),
        .raddr2        (raddr2),
        .outdata1      (outdata1),
        .outdata2      (outdata2),
        .finished_flag (finished_flag)
    );

    always #4 clk = ~clk;

    // expected (r0, r1) of one command, r0 in the upper half
    function automatic logic [2*WORD_W-1:0] fp2_ref(input alu_op_t op, input word_t a0,
                                                    input word_t a1, input word_t b0,
                                                    input word_t b1);
        int unsigned x0;
        int unsigned x1;
        int unsigned y0;
        int unsigned y1;
        int unsigned r0;
        int unsigned r1;
        x0 = 32'(a0);
        x1 = 32'(a1);
        y0 = 32'(b0);
        y1 = 32'(b1);
        case (op)
            ADD: begin
                r0 = (x0 + y0) % MODULUS;
                r1 = (x1 + y1) % MODULUS;
            end
            SUB: begin
                r0 = (x0 + MODULUS - y0) % MODULUS;
                r1 = (x1 + MODULUS - y1) % MODULUS;
            end
            DBL: begin
                r0 = (2 * x0) % MODULUS;
                r1 = (2 * x1) % MODULUS;
            end
            default: begin
                r0 = x0;
                r1 = (MODULUS - x1) % MODULUS;   // -0 stays 0
            end
        endcase
        return {word_t'(r0), word_t'(r1)};
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic rand_word(output word_t w);
        logic [31:0] rnd;
        rnd = $random(seed);
        w   = word_t'(rnd % MODULUS);   // keep operands reduced
    endtask

    task automatic load_pair(input addr_t a1, input word_t d1, input addr_t a2, input word_t d2);
        @(posedge clk);
        input_mode <= IN_LOAD;
        waddr1     <= a1;
        wdata1     <= d1;
        waddr2     <= a2;
        wdata2     <= d2;
        shadow[a1] = d1;
        shadow[a2] = d2;   // port 2 wins
    endtask

    task automatic end_load();
        @(posedge clk);
        input_mode <= IN_IDLE;
    endtask

    task automatic read_check(input addr_t a1, input addr_t a2);
        @(posedge clk);
        input_mode <= IN_RESULT;
        raddr1     <= a1;
        raddr2     <= a2;
        @(posedge clk);
        @(negedge clk);
        check($sformatf("outdata1 @%0d", a1), outdata1, shadow[a1]);
        check($sformatf("outdata2 @%0d", a2), outdata2, shadow[a2]);
    endtask

    task automatic compare_all();
        for (int i = 0; i < RAM_DEPTH; i += 2) begin
            read_check(addr_t'(i), addr_t'(i + 1));
        end
    endtask

    task automatic wait_flag(input logic level);
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (finished_flag !== level && cnt < TIMEOUT);
        if (finished_flag !== level) begin
            if (level) begin
                $display("ERROR: finished_flag never rose within %0d cycles", TIMEOUT);
            end else begin
                $display("ERROR: finished_flag never fell within %0d cycles", TIMEOUT);
            end
            errors++;
        end
    endtask

    task automatic start_cmd(input alu_op_t op, input addr_t a, input addr_t b, input addr_t r);
        @(posedge clk);
        top_cmd    <= {op, a, b, r};
        input_mode <= IN_EXEC;
    endtask

    task automatic apply_ref(input alu_op_t op, input addr_t a, input addr_t b, input addr_t r);
        addr_t                a_hi;
        addr_t                b_hi;
        addr_t                r_hi;
        logic [2*WORD_W-1:0] exp;
        a_hi = a + addr_t'(1);
        b_hi = b + addr_t'(1);
        r_hi = r + addr_t'(1);
        exp  = fp2_ref(op, shadow[a], shadow[a_hi], shadow[b], shadow[b_hi]);
        shadow[r]    = exp[2*WORD_W-1:WORD_W];
        shadow[r_hi] = exp[WORD_W-1:0];
    endtask

    task automatic run_cmd(input alu_op_t op, input addr_t a, input addr_t b, input addr_t r);
        start_cmd(op, a, b, r);
        wait_flag(1'b1);
        @(posedge clk);
        input_mode <= IN_IDLE;
        apply_ref(op, a, b, r);
    endtask

    task automatic begin_test();
        err_at_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == err_at_start) begin
            tests_passed++;
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed, %0d errors", name, errors - err_at_start);
        end
    endtask

    initial begin
        word_t       w0;
        word_t       w1;
        logic [31:0] rnd;
        alu_op_t     op;
        addr_t       a;
        addr_t       b;
        addr_t       r;
        addr_t       prev_ret;

        seed         = 45;
        errors       = 0;
        err_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        input_mode   = IN_IDLE;
        top_cmd      = '0;
        waddr1       = '0;
        waddr2       = '0;
        wdata1       = '0;
        wdata2       = '0;
        raddr1       = '0;
        raddr2       = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        @(negedge clk);
        check("finished_flag", {15'd0, finished_flag}, 16'h0000);
        check("outdata1", outdata1, 16'h0000);
        check("outdata2", outdata2, 16'h0000);
        load_pair(6'd0, 16'h1357, 6'd1, 16'h2468);
        repeat (2) @(posedge clk);   // write, then read of the new words
        @(negedge clk);
        check("outdata1", outdata1, 16'h0000);   // zero while loading
        check("outdata2", outdata2, 16'h0000);
        end_load();
        @(negedge clk);
        check("outdata1", outdata1, 16'h0000);   // read data held, still zero
        check("outdata2", outdata2, 16'h0000);
        end_test("reset_idle");

        begin_test();
        for (int i = 0; i < 16; i += 2) begin
            rand_word(w0);
            rand_word(w1);
            load_pair(addr_t'(i), w0, addr_t'(i + 1), w1);
        end
        load_pair(6'd5, 16'h1111, 6'd5, 16'h2222);
        end_load();
        for (int i = 0; i < 16; i += 2) begin
            read_check(addr_t'(i), addr_t'(i + 1));
        end
        end_test("load_readback");

        begin_test();
        for (int i = 16; i < RAM_DEPTH; i += 2) begin
            rand_word(w0);
            rand_word(w1);
            load_pair(addr_t'(i), w0, addr_t'(i + 1), w1);
        end
        load_pair(6'd16, 16'hfff0, 6'd17, 16'h0005);   // p-1
        load_pair(6'd18, 16'h0003, 6'd19, 16'h000a);
        end_load();
        run_cmd(ADD, 6'd16, 6'd18, 6'd20);   // wraps past p
        read_check(6'd20, 6'd21);
        run_cmd(SUB, 6'd16, 6'd18, 6'd22);   // 5 - 10 goes below zero
        read_check(6'd22, 6'd23);
        run_cmd(SUB, 6'd18, 6'd16, 6'd24);
        read_check(6'd24, 6'd25);
        end_test("add_sub");

        begin_test();
        load_pair(6'd30, 16'd1234, 6'd31, 16'd0);
        end_load();
        run_cmd(DBL, 6'd30, 6'd0, 6'd32);
        run_cmd(CONJ, 6'd30, 6'd0, 6'd34);
        run_cmd(CONJ, 6'd16, 6'd0, 6'd36);
        run_cmd(DBL, 6'd16, 6'd0, 6'd38);
        compare_all();
        end_test("dbl_conj");

        begin_test();
        prev_ret = '0;
        for (int n = 0; n < 20; n++) begin
            rnd = $random(seed);
            op  = alu_op_t'(rnd[1:0]);
            a   = {rnd[6:2], 1'b0};
            b   = {rnd[11:7], 1'b0};
            r   = {rnd[16:12], 1'b0};
            if (n > 0 && rnd[17]) begin
                a = prev_ret;   // chain on the last result
            end
            if (n > 0 && rnd[18]) begin
                b = prev_ret;
            end
            run_cmd(op, a, b, r);
            prev_ret = r;
        end
        compare_all();
        end_test("random_chain");

        begin_test();
        start_cmd(ADD, 6'd20, 6'd22, 6'd40);
        wait_flag(1'b1);
        repeat (3) begin
            @(negedge clk);
            check("finished_flag", {15'd0, finished_flag}, 16'h0001);
        end
        @(posedge clk);
        input_mode <= IN_IDLE;
        apply_ref(ADD, 6'd20, 6'd22, 6'd40);
        wait_flag(1'b0);
        run_cmd(SUB, 6'd40, 6'd16, 6'd42);
        read_check(6'd40, 6'd41);
        read_check(6'd42, 6'd43);
        end_test("flag_rerun");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== fp2_calc_core.f ====
rtl/fp2_calc_pkg.sv
rtl/ram_port_if.sv
rtl/fp_add_sub.sv
rtl/operand_ram.sv
rtl/fp2_alu.sv
rtl/calc_sequencer.sv
rtl/fp2_calc_core.sv
sim/tb_fp2_calc_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fp2_calc_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert \
    --top-module tb_fp2_calc_core \
    -f fp2_calc_core.f \
    -o tb_fp2_calc_core

# the log decides the result, so a failing run must not stop the script here
./obj_dir/tb_fp2_calc_core > sim.log 2>&1 || true

cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: passed"
    exit 0
else
    echo "run_sim: failed"
    exit 1
fi
